//--- mem_op_pkg.sv
// Memory opcode definitions

package mem_op_pkg;

	// ==================================================
	// Opcodes as seen on the request port
	// ==================================================
	typedef enum logic [3:0] {
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_SB,
		OP_SH,
		OP_SW
	} mem_op_t;

	// Fault code returned with every result
	typedef enum logic [1:0] {
		FLT_NONE,
		FLT_ALN,
		FLT_BUS
	} mem_fault_t;

	// Access size in bytes
	function automatic logic [2:0] fn_size(mem_op_t op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 3'd1;
			OP_LH, OP_LHU, OP_SH: return 3'd2;
			default: return 3'd4;
		endcase
	endfunction

	// Opcode writes memory
	function automatic logic fn_is_store(mem_op_t op);
		return op inside {OP_SB, OP_SH, OP_SW};
	endfunction

endpackage

//--- dram_slot_pkg.sv
// Memory slot definitions

package dram_slot_pkg;
	import mem_op_pkg::*;

	// Widest tag the read beat can carry
	localparam int BEAT_TAG_W = 8;

	// ==================================================
	// Slot state machine
	// ==================================================
	typedef enum logic [2:0] {
		SLOT_AVAIL,
		SLOT_ACTIVE,
		SLOT_DELAY,
		SLOT_ACTIVE2,
		SLOT_DELAY2
	} slot_state_t;

	// Finished access handed from execute to result
	typedef struct packed {
		logic [BEAT_TAG_W-1:0] tag;
		mem_op_t               op;
		// Byte lane of the first byte
		logic [1:0]            shift;
		logic                  two_beat;
		mem_fault_t            fault;
		// Raw words as read from the bus
		logic [31:0]           hi_word;
		logic [31:0]           lo_word;
	} rd_beat_t;

endpackage

//--- lsu_work_if.sv
// Decode to execute work item
`timescale 1ns/100ps

interface lsu_work_if import mem_op_pkg::*; #(
	parameter int ADDR_W = 16,
	parameter int TAG_W  = 4
) ();
	// Handshake
	logic              valid;
	logic              ready;
	// Request identity
	mem_op_t           op;
	logic [TAG_W-1:0]  tag;
	// Word addresses for both beats
	logic [ADDR_W-1:0] addr_lo;
	logic [ADDR_W-1:0] addr_hi;
	// Lane strobes and lane data per beat
	logic [3:0]        strb_lo;
	logic [3:0]        strb_hi;
	logic [31:0]       wdata_lo;
	logic [31:0]       wdata_hi;
	// Load merge info and early fault
	logic [1:0]        shift;
	logic              two_beat;
	mem_fault_t        fault;

	modport src (
		output valid, op, tag, addr_lo, addr_hi, strb_lo, strb_hi,
		output wdata_lo, wdata_hi, shift, two_beat, fault,
		input  ready
	);

	modport dst (
		input  valid, op, tag, addr_lo, addr_hi, strb_lo, strb_hi,
		input  wdata_lo, wdata_hi, shift, two_beat, fault,
		output ready
	);

endinterface

//--- access_decode.sv
// Request decode stage
`timescale 1ns/100ps

module access_decode import mem_op_pkg::*; #(
	parameter int ADDR_W = 16,
	parameter int TAG_W  = 4
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  mem_op_t           req_op_i,
	input  logic [ADDR_W-1:0] req_addr_i,
	input  logic [31:0]       req_wdata_i,
	input  logic [TAG_W-1:0]  req_tag_i,
	lsu_work_if.src           work
);
	logic              init_done;
	logic              accept;
	logic [3:0]        size_mask;
	logic [7:0]        strb_wide;
	logic [63:0]       data_wide;
	logic [ADDR_W-1:0] word_lo;
	logic [ADDR_W-1:0] word_hi;
	logic              page_cross;

	// ==================================================
	// Request handshake
	// ==================================================
	// Ready when the register is empty or draining and never in the first cycle out of reset
	assign req_ready_o = init_done && (!work.valid || work.ready);
	assign accept      = req_valid_i && req_ready_o;

	// Unshifted byte mask
	always_comb begin
		case (fn_size(req_op_i))
			3'd1:    size_mask = 4'b0001;
			3'd2:    size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	// Strobes and data over two words
	assign strb_wide = {4'b0000, size_mask} << req_addr_i[1:0];
	assign data_wide = {32'd0, req_wdata_i} << {req_addr_i[1:0], 3'b000};

	// Word addresses and 4 KiB page check
	assign word_lo    = {req_addr_i[ADDR_W-1:2], 2'b00};
	assign word_hi    = word_lo + ADDR_W'(4);
	assign page_cross = word_hi[ADDR_W-1:12] != word_lo[ADDR_W-1:12];

	// ==================================================
	// Work register
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			init_done  <= 1'b0;
			work.valid <= 1'b0;
		end else begin
			init_done <= 1'b1;
			if (accept)
				work.valid <= 1'b1;
			else if (work.ready)
				work.valid <= 1'b0;
		end
	end

	// Payload fields load only on accept
	always_ff @(posedge clk_i) begin
		if (accept) begin
			work.op       <= req_op_i;
			work.tag      <= req_tag_i;
			work.addr_lo  <= word_lo;
			work.addr_hi  <= word_hi;
			work.strb_lo  <= strb_wide[3:0];
			work.strb_hi  <= strb_wide[7:4];
			work.wdata_lo <= data_wide[31:0];
			work.wdata_hi <= data_wide[63:32];
			work.shift    <= req_addr_i[1:0];
			work.two_beat <= |strb_wide[7:4];
			// Straddle into the next page faults before any bus traffic
			work.fault    <= (|strb_wide[7:4] && page_cross) ? FLT_ALN : FLT_NONE;
		end
	end

	// Every item handed to execute has a first-beat lane and strobes for the whole access
	a_strb_lo: assert property (@(posedge clk_i) disable iff (rst_i)
		work.valid |-> work.strb_lo != 4'b0000 &&
			$countones({work.strb_hi, work.strb_lo}) == int'(fn_size(work.op)));

endmodule

//--- dram_slot_exec.sv
// Memory slot bus engine
`timescale 1ns/100ps

module dram_slot_exec import mem_op_pkg::*, dram_slot_pkg::*; #(
	parameter int ADDR_W = 16,
	parameter int TAG_W  = 4
) (
	input  logic              clk_i,
	input  logic              rst_i,
	lsu_work_if.dst           work,
	// AXI4-Lite write channels
	output logic              awvalid_o,
	input  logic              awready_i,
	output logic [ADDR_W-1:0] awaddr_o,
	output logic [2:0]        awprot_o,
	output logic              wvalid_o,
	input  logic              wready_i,
	output logic [31:0]       wdata_o,
	output logic [3:0]        wstrb_o,
	input  logic              bvalid_i,
	output logic              bready_o,
	input  logic [1:0]        bresp_i,
	// AXI4-Lite read channels
	output logic              arvalid_o,
	input  logic              arready_i,
	output logic [ADDR_W-1:0] araddr_o,
	output logic [2:0]        arprot_o,
	input  logic              rvalid_i,
	output logic              rready_o,
	input  logic [31:0]       rdata_i,
	input  logic [1:0]        rresp_i,
	// To result stage
	output logic              rd_valid_o,
	output rd_beat_t          rd_beat_o,
	input  logic              rd_ready_i
);
	slot_state_t       state;
	logic              store_in;
	logic              is_store;
	logic [ADDR_W-1:0] bus_addr;
	logic [ADDR_W-1:0] addr_hi_q;
	logic [3:0]        strb_hi_q;
	logic [31:0]       wdata_hi_q;
	logic              beat_done;
	logic              beat_err;
	rd_beat_t          beat_q;

	assign store_in   = fn_is_store(work.op);
	assign work.ready = state == SLOT_AVAIL;

	// Responses are always accepted, only one beat is ever outstanding
	assign bready_o = 1'b1;
	assign rready_o = 1'b1;
	assign awprot_o = 3'b000;
	assign arprot_o = 3'b000;
	assign awaddr_o = bus_addr;
	assign araddr_o = bus_addr;

	// Last handshake of the current beat
	assign beat_done = (state == SLOT_ACTIVE || state == SLOT_ACTIVE2) &&
		(is_store ? bvalid_i : rvalid_i);
	assign beat_err  = is_store ? bresp_i != 2'b00 : rresp_i != 2'b00;

	assign rd_valid_o = state == SLOT_DELAY2;
	assign rd_beat_o  = beat_q;

	// ==================================================
	// Slot state machine
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= SLOT_AVAIL;
			awvalid_o <= 1'b0;
			wvalid_o  <= 1'b0;
			arvalid_o <= 1'b0;
		end else begin
			// Each valid drops after its own handshake
			if (awready_i)
				awvalid_o <= 1'b0;
			if (wready_i)
				wvalid_o <= 1'b0;
			if (arready_i)
				arvalid_o <= 1'b0;
			case (state)
				SLOT_AVAIL:
					if (work.valid) begin
						if (work.fault != FLT_NONE) begin
							// Page cross goes straight to result
							state <= SLOT_DELAY2;
						end else begin
							state     <= SLOT_ACTIVE;
							awvalid_o <= store_in;
							wvalid_o  <= store_in;
							arvalid_o <= !store_in;
						end
					end
				SLOT_ACTIVE:
					if (beat_done)
						state <= beat_q.two_beat ? SLOT_DELAY : SLOT_DELAY2;
				SLOT_DELAY: begin
					// Launch the hi word beat
					state     <= SLOT_ACTIVE2;
					awvalid_o <= is_store;
					wvalid_o  <= is_store;
					arvalid_o <= !is_store;
				end
				SLOT_ACTIVE2:
					if (beat_done)
						state <= SLOT_DELAY2;
				SLOT_DELAY2:
					if (rd_ready_i)
						state <= SLOT_AVAIL;
				default:
					state <= SLOT_AVAIL;
			endcase
		end
	end

	// ==================================================
	// Beat payload
	// ==================================================
	always_ff @(posedge clk_i) begin
		case (state)
			SLOT_AVAIL:
				if (work.valid) begin
					is_store        <= store_in;
					bus_addr        <= work.addr_lo;
					wstrb_o         <= work.strb_lo;
					wdata_o         <= work.wdata_lo;
					addr_hi_q       <= work.addr_hi;
					strb_hi_q       <= work.strb_hi;
					wdata_hi_q      <= work.wdata_hi;
					beat_q.tag      <= BEAT_TAG_W'(work.tag);
					beat_q.op       <= work.op;
					beat_q.shift    <= work.shift;
					beat_q.two_beat <= work.two_beat;
					beat_q.fault    <= work.fault;
					beat_q.lo_word  <= 32'd0;
					beat_q.hi_word  <= 32'd0;
				end
			SLOT_ACTIVE, SLOT_ACTIVE2:
				if (beat_done) begin
					// Any error sticks, the other beat still runs
					if (beat_err)
						beat_q.fault <= FLT_BUS;
					if (!is_store && state == SLOT_ACTIVE)
						beat_q.lo_word <= rdata_i;
					if (!is_store && state == SLOT_ACTIVE2)
						beat_q.hi_word <= rdata_i;
				end
			SLOT_DELAY: begin
				// Move to the high word
				bus_addr <= addr_hi_q;
				wstrb_o  <= strb_hi_q;
				wdata_o  <= wdata_hi_q;
			end
			default: ;
		endcase
	end

	// AXI valids hold until their handshake
	property p_valid_hold(logic vld, logic rdy);
		@(posedge clk_i) disable iff (rst_i) vld && !rdy |=> vld;
	endproperty
	a_aw_hold: assert property (p_valid_hold(awvalid_o, awready_i));
	a_w_hold:  assert property (p_valid_hold(wvalid_o, wready_i));
	a_ar_hold: assert property (p_valid_hold(arvalid_o, arready_i));

	// New work only lands on an idle slot with a quiet bus
	a_accept_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		work.valid && work.ready |->
			state == SLOT_AVAIL && !awvalid_o && !wvalid_o && !arvalid_o);

endmodule

//--- load_result.sv
// Load result formatter
`timescale 1ns/100ps

module load_result import mem_op_pkg::*, dram_slot_pkg::*; #(
	parameter int TAG_W = 4
) (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             rd_valid_i,
	input  rd_beat_t         rd_beat_i,
	output logic             rd_ready_o,
	output logic             resp_valid_o,
	input  logic             resp_ready_i,
	output logic [TAG_W-1:0] resp_tag_o,
	output logic [31:0]      resp_data_o,
	output mem_fault_t       resp_exc_o
);
	logic [63:0] merged;
	logic [31:0] load_val;

	// Empty or draining
	assign rd_ready_o = !resp_valid_o || resp_ready_i;

	// Both words, first byte moved down to lane 0
	assign merged = {rd_beat_i.hi_word, rd_beat_i.lo_word} >> {rd_beat_i.shift, 3'b000};

	// Size and extension per opcode, stores give zero
	always_comb begin
		case (rd_beat_i.op)
			OP_LB:   load_val = {{24{merged[7]}}, merged[7:0]};
			OP_LBU:  load_val = {24'd0, merged[7:0]};
			OP_LH:   load_val = {{16{merged[15]}}, merged[15:0]};
			OP_LHU:  load_val = {16'd0, merged[15:0]};
			OP_LW:   load_val = merged[31:0];
			default: load_val = 32'd0;
		endcase
		// Faulted accesses carry no data
		if (rd_beat_i.fault != FLT_NONE)
			load_val = 32'd0;
	end

	// ==================================================
	// One-entry output register
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i)
			resp_valid_o <= 1'b0;
		else if (rd_valid_i && rd_ready_o)
			resp_valid_o <= 1'b1;
		else if (resp_ready_i)
			resp_valid_o <= 1'b0;
	end

	always_ff @(posedge clk_i) begin
		if (rd_valid_i && rd_ready_o) begin
			resp_tag_o  <= rd_beat_i.tag[TAG_W-1:0];
			resp_data_o <= load_val;
			resp_exc_o  <= rd_beat_i.fault;
		end
	end

endmodule

//--- lsu_dram_top.sv
// Load/store memory slot
`timescale 1ns/100ps

module lsu_dram_top import mem_op_pkg::*, dram_slot_pkg::*; #(
	parameter int ADDR_W = 16,
	parameter int TAG_W  = 4
) (
	input  logic              clk_i,
	input  logic              rst_i,
	// Request port
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  mem_op_t           req_op_i,
	input  logic [ADDR_W-1:0] req_addr_i,
	input  logic [31:0]       req_wdata_i,
	input  logic [TAG_W-1:0]  req_tag_i,
	// Result port
	output logic              resp_valid_o,
	input  logic              resp_ready_i,
	output logic [TAG_W-1:0]  resp_tag_o,
	output logic [31:0]       resp_data_o,
	output mem_fault_t        resp_exc_o,
	// AXI4-Lite master
	output logic              awvalid_o,
	input  logic              awready_i,
	output logic [ADDR_W-1:0] awaddr_o,
	output logic [2:0]        awprot_o,
	output logic              wvalid_o,
	input  logic              wready_i,
	output logic [31:0]       wdata_o,
	output logic [3:0]        wstrb_o,
	input  logic              bvalid_i,
	output logic              bready_o,
	input  logic [1:0]        bresp_i,
	output logic              arvalid_o,
	input  logic              arready_i,
	output logic [ADDR_W-1:0] araddr_o,
	output logic [2:0]        arprot_o,
	input  logic              rvalid_i,
	output logic              rready_o,
	input  logic [31:0]       rdata_i,
	input  logic [1:0]        rresp_i
);
	// Execute to result
	logic     rd_valid;
	logic     rd_ready;
	rd_beat_t rd_beat;

	lsu_work_if #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) work0 ();

	access_decode #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) decode0 (
		.clk_i(clk_i), .rst_i(rst_i),
		.req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
		.req_op_i(req_op_i), .req_addr_i(req_addr_i),
		.req_wdata_i(req_wdata_i), .req_tag_i(req_tag_i),
		.work(work0.src)
	);

	dram_slot_exec #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) exec0 (
		.clk_i(clk_i), .rst_i(rst_i), .work(work0.dst),
		.awvalid_o(awvalid_o), .awready_i(awready_i), .awaddr_o(awaddr_o),
		.awprot_o(awprot_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
		.wdata_o(wdata_o), .wstrb_o(wstrb_o), .bvalid_i(bvalid_i),
		.bready_o(bready_o), .bresp_i(bresp_i), .arvalid_o(arvalid_o),
		.arready_i(arready_i), .araddr_o(araddr_o), .arprot_o(arprot_o),
		.rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i),
		.rresp_i(rresp_i),
		.rd_valid_o(rd_valid), .rd_beat_o(rd_beat), .rd_ready_i(rd_ready)
	);

	load_result #(.TAG_W(TAG_W)) result0 (
		.clk_i(clk_i), .rst_i(rst_i),
		.rd_valid_i(rd_valid), .rd_beat_i(rd_beat), .rd_ready_o(rd_ready),
		.resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
		.resp_tag_o(resp_tag_o), .resp_data_o(resp_data_o),
		.resp_exc_o(resp_exc_o)
	);

endmodule

//--- tb_axi_mem.sv
// AXI4-Lite memory responder
`timescale 1ns/100ps

module tb_axi_mem (
	input  logic        clk_i,
	input  logic        rst_i,
	// Write channels
	input  logic        awvalid_i,
	output logic        awready_o,
	input  logic [15:0] awaddr_i,
	input  logic        wvalid_i,
	output logic        wready_o,
	input  logic [31:0] wdata_i,
	input  logic [3:0]  wstrb_i,
	output logic        bvalid_o,
	input  logic        bready_i,
	output logic [1:0]  bresp_o,
	// Read channels
	input  logic        arvalid_i,
	output logic        arready_o,
	input  logic [15:0] araddr_i,
	output logic        rvalid_o,
	input  logic        rready_i,
	output logic [31:0] rdata_o,
	output logic [1:0]  rresp_o
);
	// 64 KiB byte store
	logic [7:0]  mem [0:65535];
	logic        aw_got;
	logic        w_got;
	logic        b_pend;
	logic        b_err;
	logic        r_pend;
	logic [15:0] aw_addr;
	logic [15:0] r_addr;
	logic [31:0] w_data;
	logic [3:0]  w_strb;

	// Top page of the map answers SLVERR
	function automatic logic in_err_page(logic [15:0] a);
		return a[15:12] == 4'hf;
	endfunction

	// Image depends on every address bit
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'((i * 40503) >> 7) ^ 8'(i >> 8) ^ 8'h5a;
	end

	// ==================================================
	// Handshake bookkeeping on the rising edge
	// ==================================================
	always @(posedge clk_i) begin
		if (rst_i) begin
			aw_got <= 1'b0;
			w_got  <= 1'b0;
			b_pend <= 1'b0;
			r_pend <= 1'b0;
		end else begin
			if (awvalid_i && awready_o) begin
				aw_addr <= awaddr_i;
				aw_got  <= 1'b1;
			end
			if (wvalid_i && wready_o) begin
				w_data <= wdata_i;
				w_strb <= wstrb_i;
				w_got  <= 1'b1;
			end
			// Address and data both in, commit unless on the error page
			if (aw_got && w_got && !b_pend) begin
				b_err  <= in_err_page(aw_addr);
				if (!in_err_page(aw_addr)) begin
					for (int i = 0; i < 4; i++)
						if (w_strb[i])
							mem[{aw_addr[15:2], 2'(i)}] = w_data[8*i +: 8];
				end
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				b_pend <= 1'b1;
			end
			if (bvalid_o && bready_i)
				b_pend <= 1'b0;
			if (arvalid_i && arready_o) begin
				r_addr <= araddr_i;
				r_pend <= 1'b1;
			end
			if (rvalid_o && rready_i)
				r_pend <= 1'b0;
		end
	end

	// ==================================================
	// Outputs change on the falling edge
	// ==================================================
	always @(negedge clk_i) begin
		if (rst_i) begin
			awready_o <= 1'b0;
			wready_o  <= 1'b0;
			arready_o <= 1'b0;
			bvalid_o  <= 1'b0;
			rvalid_o  <= 1'b0;
		end else begin
			// Readies drop about one cycle in four
			awready_o <= $urandom_range(0, 3) != 0;
			wready_o  <= $urandom_range(0, 3) != 0;
			arready_o <= $urandom_range(0, 3) != 0;
			// Responses come after a random wait, then hold until taken
			bvalid_o  <= b_pend && (bvalid_o || $urandom_range(0, 2) == 0);
			bresp_o   <= b_err ? 2'b10 : 2'b00;
			rvalid_o  <= r_pend && (rvalid_o || $urandom_range(0, 2) == 0);
			rresp_o   <= in_err_page(r_addr) ? 2'b10 : 2'b00;
			rdata_o   <= {mem[{r_addr[15:2], 2'd3}], mem[{r_addr[15:2], 2'd2}],
				mem[{r_addr[15:2], 2'd1}], mem[{r_addr[15:2], 2'd0}]};
		end
	end

endmodule

//--- tb_lsu_dram.sv
// Memory slot testbench
`timescale 1ns/100ps

module tb_lsu_dram import mem_op_pkg::*; ();
	localparam int NUM_REQ    = 1500;
	localparam int MAX_CYCLES = NUM_REQ * 200 + 100;

	typedef struct packed {
		logic [3:0]  tag;
		logic [31:0] data;
		mem_fault_t  fault;
	} expect_t;

	logic        clk_i = 1'b1;
	logic        rst_i = 1'b1;
	logic        req_valid_i = 1'b0;
	logic        req_ready_o;
	mem_op_t     req_op_i = OP_LB;
	logic [15:0] req_addr_i = 16'd0;
	logic [31:0] req_wdata_i = 32'd0;
	logic [3:0]  req_tag_i = 4'd0;
	logic        resp_valid_o;
	logic        resp_ready_i = 1'b0;
	logic [3:0]  resp_tag_o;
	logic [31:0] resp_data_o;
	mem_fault_t  resp_exc_o;
	// AXI4-Lite between DUT and memory
	logic        awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i, bready_o;
	logic        arvalid_o, arready_i, rvalid_i, rready_o;
	logic [15:0] awaddr_o, araddr_o;
	logic [2:0]  awprot_o, arprot_o;
	logic [31:0] wdata_o, rdata_i;
	logic [3:0]  wstrb_o;
	logic [1:0]  bresp_i, rresp_i;

	// Shadow memory and the queue of responses still owed in request order
	logic [7:0]  shadow [0:65535];
	expect_t     exp_q [$];
	int          resp_count = 0;
	int          cycles = 0;

	lsu_dram_top #(.ADDR_W(16), .TAG_W(4)) dut0 (.*);

	tb_axi_mem mem0 (
		.clk_i(clk_i), .rst_i(rst_i),
		.awvalid_i(awvalid_o), .awready_o(awready_i), .awaddr_i(awaddr_o),
		.wvalid_i(wvalid_o), .wready_o(wready_i), .wdata_i(wdata_o), .wstrb_i(wstrb_o),
		.bvalid_o(bvalid_i), .bready_i(bready_o), .bresp_o(bresp_i),
		.arvalid_i(arvalid_o), .arready_o(arready_i), .araddr_i(araddr_o),
		.rvalid_o(rvalid_i), .rready_i(rready_o), .rdata_o(rdata_i), .rresp_o(rresp_i)
	);

	always #2 clk_i = ~clk_i;

	task automatic abort_run(string why);
		$display("Test failures found");
		$fatal(1, "%s", why);
	endtask

	task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			abort_run("A checked value did not match");
		end
	endtask

	// ==================================================
	// Reference model of one access
	// ==================================================
	function automatic expect_t model_access(mem_op_t op, logic [15:0] addr,
		logic [31:0] wdata, logic [3:0] tag);
		int          size;
		logic [15:0] lo_word;
		logic [15:0] hi_word;
		logic        two;
		logic [31:0] val;
		expect_t     e;
		case (op)
			OP_LB, OP_LBU, OP_SB: size = 1;
			OP_LH, OP_LHU, OP_SH: size = 2;
			default:              size = 4;
		endcase
		e.tag     = tag;
		e.data    = 32'd0;
		e.fault   = FLT_NONE;
		lo_word   = {addr[15:2], 2'b00};
		hi_word   = lo_word + 16'd4;
		two       = int'(addr[1:0]) + size > 4;
		// Page cross takes priority over a bus error and neither one touches memory
		if (two && hi_word[15:12] != lo_word[15:12])
			e.fault = FLT_ALN;
		else if (lo_word[15:12] == 4'hf || (two && hi_word[15:12] == 4'hf))
			e.fault = FLT_BUS;
		else if (op inside {OP_SB, OP_SH, OP_SW}) begin
			for (int i = 0; i < size; i++)
				shadow[addr + 16'(i)] = wdata[8*i +: 8];
		end else begin
			val = 32'd0;
			for (int i = 0; i < size; i++)
				val[8*i +: 8] = shadow[addr + 16'(i)];
			if (op == OP_LB)
				val = {{24{val[7]}}, val[7:0]};
			if (op == OP_LH)
				val = {{16{val[15]}}, val[15:0]};
			e.data = val;
		end
		return e;
	endfunction

	// Addresses leaning on word edges, page edges and the error page
	function automatic logic [15:0] pick_addr();
		logic [15:0] r;
		r = 16'($urandom);
		case ($urandom_range(0, 5))
			0:       return r;
			1:       return {r[15:2], 2'b00};
			2:       return {8'h01, 2'b00, r[5:0]};
			3:       return {r[15:12], 10'h3ff, r[1:0]};
			4:       return {4'hf, r[11:0]};
			default: return {4'h2, 8'hff, r[3:0]};
		endcase
	endfunction

	// ==================================================
	// Request acceptance and response checks
	// ==================================================
	always @(posedge clk_i) begin
		expect_t e;
		if (rst_i) begin
			// Shadow starts from the memory image
			for (int i = 0; i < 65536; i++)
				shadow[i] = mem0.mem[i];
		end else begin
			// Plain unprivileged data access on both address channels
			if (awvalid_o)
				check_eq("awprot", 32'd0, 32'(awprot_o));
			if (arvalid_o)
				check_eq("arprot", 32'd0, 32'(arprot_o));
			if (resp_valid_o && resp_ready_i) begin
				if (exp_q.size() == 0)
					abort_run("A response arrived with no request outstanding");
				else begin
					e = exp_q.pop_front();
					check_eq($sformatf("resp %0d tag", resp_count), 32'(e.tag), 32'(resp_tag_o));
					check_eq($sformatf("resp %0d data", resp_count), e.data, resp_data_o);
					check_eq($sformatf("resp %0d fault", resp_count), 32'(e.fault),
						32'(resp_exc_o));
					resp_count++;
				end
			end
			if (req_valid_i && req_ready_o)
				exp_q.push_back(model_access(req_op_i, req_addr_i, req_wdata_i, req_tag_i));
		end
	end

	// Random result back-pressure
	always @(negedge clk_i)
		resp_ready_i = $urandom_range(0, 9) < 7;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > MAX_CYCLES)
			abort_run("The run timed out before all responses arrived");
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h508f_4736));
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		for (int n = 0; n < NUM_REQ; n++) begin
			req_valid_i = 1'b1;
			req_op_i    = mem_op_t'(4'($urandom_range(0, 7)));
			req_addr_i  = pick_addr();
			req_wdata_i = $urandom;
			req_tag_i   = 4'(n);
			// Hold until taken
			@(posedge clk_i);
			while (!req_ready_o)
				@(posedge clk_i);
			@(negedge clk_i);
			req_valid_i = 1'b0;
			repeat ($urandom_range(0, 2)) @(negedge clk_i);
		end
		while (resp_count < NUM_REQ)
			@(posedge clk_i);
		// Quiet period catches duplicate responses
		repeat (20) @(posedge clk_i);
		for (int i = 0; i < 65536; i++)
			check_eq($sformatf("mem[%04h]", i), 32'(shadow[i]), 32'(mem0.mem[i]));
		if (resp_count == NUM_REQ && exp_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run($sformatf("Got %0d responses for %0d requests", resp_count, NUM_REQ));
		end
	end

endmodule

//--- lsu_dram_top.f
mem_op_pkg.sv
dram_slot_pkg.sv
lsu_work_if.sv
access_decode.sv
dram_slot_exec.sv
load_result.sv
lsu_dram_top.sv
tb_axi_mem.sv
tb_lsu_dram.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory slot testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f lsu_dram_top.f \
	--top-module tb_lsu_dram \
	-o sim_lsu_dram

# The simulator exit code is not trusted, the log decides
./obj_dir/sim_lsu_dram 2>&1 | tee sim.log

if grep -q '^All tests passed!$' sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
